//--- lsu_sched_pkg.sv
/*
  Shared sizes, scheduler entry layout and state encodings for the LSU
  issue scheduler. Import with a wildcard in each module header.
*/
`default_nettype none

package lsu_sched_pkg;

  // --------------------------------------------------------------------------
  // Sizes
  // --------------------------------------------------------------------------
  localparam int LSU_QUEUE_DEPTH = 4;
  localparam int LSU_IDX_W       = 2;
  localparam int LSU_TAG_W       = 4;
  localparam int LSU_RNID_W      = 5;
  localparam int LSU_XLEN        = 16;
  localparam int LSU_AGE_W       = 3;

  typedef enum logic {
    LSU_OP_LOAD  = 1'b0,
    LSU_OP_STORE = 1'b1
  } lsu_op_t;

  typedef enum logic [2:0] {
    LSU_SCHED_INIT     = 3'd0,
    LSU_SCHED_WAIT     = 3'd1,
    LSU_SCHED_ISSUED   = 3'd2,
    LSU_SCHED_EX2      = 3'd3,
    LSU_SCHED_HAZ_WAIT = 3'd4,
    LSU_SCHED_CLEAR    = 3'd5
  } lsu_sched_state_t;

  // Hazard seen by EX1
  typedef enum logic [1:0] {
    LSU_HAZ_NONE     = 2'd0,
    LSU_HAZ_TLB_MISS = 2'd1
  } lsu_haz_t;

  typedef struct packed {
    logic                  valid;
    lsu_op_t               op;
    logic [LSU_TAG_W-1:0]  tag;
    logic [LSU_RNID_W-1:0] rs1_rnid;    // Base register id
    logic                  rs1_ready;
    logic [LSU_XLEN-1:0]   rs1_data;    // Base value once woken up
    logic [LSU_XLEN-1:0]   imm;
    logic                  need_oldest; // Stores only
    logic                  tlb_done;    // Set after a resolved miss
  } lsu_issue_entry_t;

endpackage

`default_nettype wire

//--- lsu_pipe_if.sv
/*
  Issue and update signals between the issue queue and the execute pipe.
  The queue drives issue fields, the pipe drives EX1 and EX2 updates.
*/
`timescale 1ns/1ps
`default_nettype none

interface lsu_pipe_if
  import lsu_sched_pkg::*;
  ();

  // Issue, one op per cycle at most
  logic                 iss_valid;
  logic [LSU_IDX_W-1:0] iss_idx;
  logic [LSU_TAG_W-1:0] iss_tag;
  lsu_op_t              iss_op;
  logic [LSU_XLEN-1:0]  iss_base;
  logic [LSU_XLEN-1:0]  iss_imm;
  logic                 iss_tlb_done;

  // EX1 translation result
  logic                 ex1_update;
  logic [LSU_IDX_W-1:0] ex1_idx;
  lsu_haz_t             ex1_haz;

  // EX2 completion
  logic                 ex2_update;
  logic [LSU_IDX_W-1:0] ex2_idx;
  logic [LSU_TAG_W-1:0] ex2_tag;
  lsu_op_t              ex2_op;
  logic [LSU_XLEN-1:0]  ex2_addr;

  modport queue (
    output iss_valid, iss_idx, iss_tag, iss_op, iss_base, iss_imm, iss_tlb_done,
    input  ex1_update, ex1_idx, ex1_haz, ex2_update, ex2_idx
  );

  modport pipe (
    input  iss_valid, iss_idx, iss_tag, iss_op, iss_base, iss_imm, iss_tlb_done,
    output ex1_update, ex1_idx, ex1_haz,
    output ex2_update, ex2_idx, ex2_tag, ex2_op, ex2_addr
  );

endinterface

`default_nettype wire

//--- lsu_issue_decode.sv
/*
  Turns the plain put inputs into a scheduler entry. A writeback in the
  put cycle is folded in so the base operand is not missed.
*/
`timescale 1ns/1ps
`default_nettype none

module lsu_issue_decode
  import lsu_sched_pkg::*;
(
  input  logic                  i_put,
  input  lsu_op_t               i_put_op,
  input  logic [LSU_TAG_W-1:0]  i_put_tag,
  input  logic [LSU_RNID_W-1:0] i_put_rs1_rnid,
  input  logic                  i_put_rs1_ready,
  input  logic [LSU_XLEN-1:0]   i_put_rs1_data,
  input  logic [LSU_XLEN-1:0]   i_put_imm,
  input  logic                  i_full,
  input  logic                  i_wr_valid,
  input  logic [LSU_RNID_W-1:0] i_wr_rnid,
  input  logic [LSU_XLEN-1:0]   i_wr_data,
  output logic                  o_alloc,
  output lsu_issue_entry_t      o_entry
);

  logic w_wr_hit;

  // Writeback racing the put
  assign w_wr_hit = i_wr_valid & !i_put_rs1_ready & (i_wr_rnid == i_put_rs1_rnid);
  assign o_alloc  = i_put & !i_full;

  always_comb begin
    o_entry             = '0;
    o_entry.valid       = o_alloc; // Also tells every entry that a put happened
    o_entry.op          = i_put_op;
    o_entry.tag         = i_put_tag;
    o_entry.rs1_rnid    = i_put_rs1_rnid;
    o_entry.rs1_ready   = i_put_rs1_ready | w_wr_hit;
    o_entry.rs1_data    = w_wr_hit ? i_wr_data : i_put_rs1_data;
    o_entry.imm         = i_put_imm;
    o_entry.need_oldest = (i_put_op == LSU_OP_STORE);
    o_entry.tlb_done    = 1'b0;
  end

endmodule

`default_nettype wire

//--- lsu_issue_entry.sv
/*
  One scheduler entry. Holds the op from put until completion, wakes up on
  the writeback bus and follows the pipe through EX1 and EX2.
*/
`timescale 1ns/1ps
`default_nettype none

module lsu_issue_entry
  import lsu_sched_pkg::*;
(
  input  logic                  i_clk,
  input  logic                  i_reset_n,

  input  logic                  i_put,
  input  lsu_issue_entry_t      i_put_entry,

  input  logic                  i_wr_valid,
  input  logic [LSU_RNID_W-1:0] i_wr_rnid,
  input  logic [LSU_XLEN-1:0]   i_wr_data,

  input  logic                  i_picked,
  input  logic                  i_ex1_update,
  input  lsu_haz_t              i_ex1_haz,
  input  logic                  i_ex2_update,
  input  logic                  i_tlb_resolve,
  input  logic                  i_flush,
  input  logic                  i_older_valid,

  output logic                  o_entry_valid,
  output logic                  o_entry_ready,
  output lsu_issue_entry_t      o_entry,
  output logic [LSU_AGE_W-1:0]  o_age
);

  lsu_sched_state_t     r_state;
  lsu_sched_state_t     w_state_next;
  lsu_issue_entry_t     r_entry;
  lsu_issue_entry_t     w_entry_next;
  logic [LSU_AGE_W-1:0] r_age;
  logic                 w_wakeup;
  logic                 w_other_put;

  assign w_wakeup = r_entry.valid & !r_entry.rs1_ready & i_wr_valid &
                    (i_wr_rnid == r_entry.rs1_rnid);

  always_comb begin
    w_state_next = r_state;
    w_entry_next = r_entry;

    if (w_wakeup) begin
      w_entry_next.rs1_ready = 1'b1;
      w_entry_next.rs1_data  = i_wr_data;
    end

    case (r_state)
      LSU_SCHED_INIT: begin
        if (i_put) begin
          w_entry_next = i_put_entry;
          w_state_next = LSU_SCHED_WAIT;
        end
      end
      LSU_SCHED_WAIT: begin
        if (i_picked) begin
          w_state_next = LSU_SCHED_ISSUED;
        end
      end
      LSU_SCHED_ISSUED: begin
        // Sits here through EX0 until EX1 reports
        if (i_ex1_update) begin
          w_state_next = (i_ex1_haz != LSU_HAZ_NONE) ? LSU_SCHED_HAZ_WAIT : LSU_SCHED_EX2;
        end
      end
      LSU_SCHED_EX2: begin
        if (i_ex2_update) begin
          w_state_next = LSU_SCHED_CLEAR;
        end
      end
      LSU_SCHED_HAZ_WAIT: begin
        if (i_tlb_resolve) begin
          w_entry_next.tlb_done = 1'b1; // Replay will translate
          w_state_next          = LSU_SCHED_WAIT;
        end
      end
      LSU_SCHED_CLEAR: begin
        w_entry_next.valid = 1'b0;
        w_state_next       = LSU_SCHED_INIT;
      end
      default: begin
        w_state_next = LSU_SCHED_INIT;
      end
    endcase

    // Flush kills the entry whatever its state
    if (i_flush) begin
      w_entry_next.valid = 1'b0;
      w_state_next       = LSU_SCHED_INIT;
    end
  end

  always_ff @(posedge i_clk, negedge i_reset_n) begin
    if (!i_reset_n) begin
      r_state <= LSU_SCHED_INIT;
      r_entry <= '0;
    end else begin
      r_state <= w_state_next;
      r_entry <= w_entry_next;
    end
  end

  // ------------------------------------------------------------------------
  // Age, bigger is older, saturates at the top
  // ------------------------------------------------------------------------
  assign w_other_put = i_put_entry.valid & !i_put & r_entry.valid;

  always_ff @(posedge i_clk, negedge i_reset_n) begin
    if (!i_reset_n) begin
      r_age <= '0;
    end else if (i_flush || i_put) begin
      r_age <= '0;
    end else if (w_other_put && !(&r_age)) begin
      r_age <= r_age + 1'b1;
    end
  end

  assign o_entry_valid = r_entry.valid;
  assign o_entry_ready = r_entry.valid & (r_state == LSU_SCHED_WAIT) & r_entry.rs1_ready &
                         (!r_entry.need_oldest | !i_older_valid);
  assign o_entry       = r_entry;
  assign o_age         = r_age;

  // Queue only picks an entry that reported ready
  a_pick_ready: assert property (@(posedge i_clk) disable iff (!i_reset_n)
    i_picked |-> o_entry_ready);

endmodule

`default_nettype wire

//--- lsu_issue_queue.sv
/*
  Four-entry issue queue. Allocates to the lowest free slot, orders
  stores by age and issues the lowest-index ready entry each cycle.
*/
`timescale 1ns/1ps
`default_nettype none

module lsu_issue_queue
  import lsu_sched_pkg::*;
(
  input  logic                  i_clk,
  input  logic                  i_reset_n,
  input  logic                  i_alloc,
  input  lsu_issue_entry_t      i_alloc_entry,
  input  logic                  i_wr_valid,
  input  logic [LSU_RNID_W-1:0] i_wr_rnid,
  input  logic [LSU_XLEN-1:0]   i_wr_data,
  input  logic                  i_tlb_resolve,
  input  logic                  i_flush,
  lsu_pipe_if.queue             pipe_if,
  output logic                  o_full
);

  logic [LSU_QUEUE_DEPTH-1:0] w_valid;
  logic [LSU_QUEUE_DEPTH-1:0] w_ready;
  logic [LSU_QUEUE_DEPTH-1:0] w_put;
  logic [LSU_QUEUE_DEPTH-1:0] w_picked;
  logic [LSU_QUEUE_DEPTH-1:0] w_older_valid;
  lsu_issue_entry_t           w_entry [LSU_QUEUE_DEPTH];
  logic [LSU_AGE_W-1:0]       w_age   [LSU_QUEUE_DEPTH];
  logic [LSU_IDX_W-1:0]       w_pick_idx;

  // Lowest free slot and lowest ready slot
  always_comb begin
    w_put      = '0;
    w_picked   = '0;
    w_pick_idx = '0;
    for (int i = LSU_QUEUE_DEPTH - 1; i >= 0; i--) begin
      if (!w_valid[i]) begin
        w_put    = '0;
        w_put[i] = i_alloc;
      end
      if (w_ready[i]) begin
        w_picked    = '0;
        w_picked[i] = 1'b1;
        w_pick_idx  = LSU_IDX_W'(i);
      end
    end
  end

  // Older valid entry per slot where a lower index wins a saturated tie
  always_comb begin
    w_older_valid = '0;
    for (int i = 0; i < LSU_QUEUE_DEPTH; i++) begin
      for (int j = 0; j < LSU_QUEUE_DEPTH; j++) begin
        if ((j != i) && w_valid[j] &&
            ((w_age[j] > w_age[i]) || ((w_age[j] == w_age[i]) && (j < i)))) begin
          w_older_valid[i] = 1'b1;
        end
      end
    end
  end

  for (genvar g = 0; g < LSU_QUEUE_DEPTH; g++) begin : g_entry
    lsu_issue_entry u_entry (
      .i_clk         (i_clk),
      .i_reset_n     (i_reset_n),
      .i_put         (w_put[g]),
      .i_put_entry   (i_alloc_entry),
      .i_wr_valid    (i_wr_valid),
      .i_wr_rnid     (i_wr_rnid),
      .i_wr_data     (i_wr_data),
      .i_picked      (w_picked[g]),
      .i_ex1_update  (pipe_if.ex1_update & (pipe_if.ex1_idx == LSU_IDX_W'(g))),
      .i_ex1_haz     (pipe_if.ex1_haz),
      .i_ex2_update  (pipe_if.ex2_update & (pipe_if.ex2_idx == LSU_IDX_W'(g))),
      .i_tlb_resolve (i_tlb_resolve),
      .i_flush       (i_flush),
      .i_older_valid (w_older_valid[g]),
      .o_entry_valid (w_valid[g]),
      .o_entry_ready (w_ready[g]),
      .o_entry       (w_entry[g]),
      .o_age         (w_age[g])
    );
  end

  assign pipe_if.iss_valid    = |w_ready;
  assign pipe_if.iss_idx      = w_pick_idx;
  assign pipe_if.iss_tag      = w_entry[w_pick_idx].tag;
  assign pipe_if.iss_op       = w_entry[w_pick_idx].op;
  assign pipe_if.iss_base     = w_entry[w_pick_idx].rs1_data;
  assign pipe_if.iss_imm      = w_entry[w_pick_idx].imm;
  assign pipe_if.iss_tlb_done = w_entry[w_pick_idx].tlb_done;

  assign o_full = &w_valid;

  // A slot holds at most one op in the pipe at a time
  a_one_in_flight: assert property (@(posedge i_clk) disable iff (!i_reset_n)
    pipe_if.iss_valid |->
      !(pipe_if.ex1_update && (pipe_if.ex1_idx == pipe_if.iss_idx)) &&
      !(pipe_if.ex2_update && (pipe_if.ex2_idx == pipe_if.iss_idx)));

endmodule

`default_nettype wire

//--- lsu_exec_pipe.sv
/*
  Three-stage execute pipe. EX0 adds base and immediate, EX1 checks the
  translation, EX2 reports the hit. Flush empties every stage.
*/
`timescale 1ns/1ps
`default_nettype none

module lsu_exec_pipe
  import lsu_sched_pkg::*;
(
  input  logic     i_clk,
  input  logic     i_reset_n,
  input  logic     i_flush,
  lsu_pipe_if.pipe pipe_if
);

  logic                 r_ex0_valid;
  logic [LSU_IDX_W-1:0] r_ex0_idx;
  logic [LSU_TAG_W-1:0] r_ex0_tag;
  lsu_op_t              r_ex0_op;
  logic [LSU_XLEN-1:0]  r_ex0_base;
  logic [LSU_XLEN-1:0]  r_ex0_imm;
  logic                 r_ex0_tlb_done;
  logic [LSU_XLEN-1:0]  w_ex0_addr;

  logic                 r_ex1_valid;
  logic [LSU_IDX_W-1:0] r_ex1_idx;
  logic [LSU_TAG_W-1:0] r_ex1_tag;
  lsu_op_t              r_ex1_op;
  logic [LSU_XLEN-1:0]  r_ex1_addr;
  logic                 r_ex1_tlb_done;
  logic                 w_ex1_miss;

  logic                 r_ex2_valid;
  logic [LSU_IDX_W-1:0] r_ex2_idx;
  logic [LSU_TAG_W-1:0] r_ex2_tag;
  lsu_op_t              r_ex2_op;
  logic [LSU_XLEN-1:0]  r_ex2_addr;

  assign w_ex0_addr = r_ex0_base + r_ex0_imm;
  assign w_ex1_miss = r_ex1_addr[LSU_XLEN-1] & !r_ex1_tlb_done; // Upper half is unmapped

  always_ff @(posedge i_clk, negedge i_reset_n) begin
    if (!i_reset_n) begin
      r_ex0_valid <= 1'b0;
      r_ex1_valid <= 1'b0;
      r_ex2_valid <= 1'b0;
    end else begin
      r_ex0_valid <= pipe_if.iss_valid & !i_flush;
      r_ex1_valid <= r_ex0_valid & !i_flush;
      r_ex2_valid <= r_ex1_valid & !w_ex1_miss & !i_flush; // Miss drops out here
    end
  end

  always_ff @(posedge i_clk) begin
    r_ex0_idx      <= pipe_if.iss_idx;
    r_ex0_tag      <= pipe_if.iss_tag;
    r_ex0_op       <= pipe_if.iss_op;
    r_ex0_base     <= pipe_if.iss_base;
    r_ex0_imm      <= pipe_if.iss_imm;
    r_ex0_tlb_done <= pipe_if.iss_tlb_done;
    r_ex1_idx      <= r_ex0_idx;
    r_ex1_tag      <= r_ex0_tag;
    r_ex1_op       <= r_ex0_op;
    r_ex1_addr     <= w_ex0_addr;
    r_ex1_tlb_done <= r_ex0_tlb_done;
    r_ex2_idx      <= r_ex1_idx;
    r_ex2_tag      <= r_ex1_tag;
    r_ex2_op       <= r_ex1_op;
    r_ex2_addr     <= r_ex1_addr;
  end

  assign pipe_if.ex1_update = r_ex1_valid;
  assign pipe_if.ex1_idx    = r_ex1_idx;
  assign pipe_if.ex1_haz    = w_ex1_miss ? LSU_HAZ_TLB_MISS : LSU_HAZ_NONE;

  assign pipe_if.ex2_update = r_ex2_valid;
  assign pipe_if.ex2_idx    = r_ex2_idx;
  assign pipe_if.ex2_tag    = r_ex2_tag;
  assign pipe_if.ex2_op     = r_ex2_op;
  assign pipe_if.ex2_addr   = r_ex2_addr;

endmodule

`default_nettype wire

//--- lsu_result.sv
/*
  Result stage. Registers the EX2 completion into the done outputs and
  drops it when a flush arrives in the same cycle.
*/
`timescale 1ns/1ps
`default_nettype none

module lsu_result
  import lsu_sched_pkg::*;
(
  input  logic                 i_clk,
  input  logic                 i_reset_n,
  input  logic                 i_flush,
  lsu_pipe_if.pipe             pipe_if,
  output logic                 o_done,
  output logic [LSU_TAG_W-1:0] o_done_tag,
  output lsu_op_t              o_done_op,
  output logic [LSU_XLEN-1:0]  o_done_addr
);

  logic                         r_done;
  logic [LSU_TAG_W-1:0]         r_done_tag;
  lsu_op_t                      r_done_op;
  logic [LSU_XLEN-1:0]          r_done_addr;
  logic [(1 << LSU_TAG_W)-1:0]  r_tag_done; // Completed since last issue

  always_ff @(posedge i_clk, negedge i_reset_n) begin
    if (!i_reset_n) begin
      r_done     <= 1'b0;
      r_tag_done <= '0;
    end else begin
      r_done <= pipe_if.ex2_update & !i_flush;
      if (pipe_if.iss_valid) begin
        r_tag_done[pipe_if.iss_tag] <= 1'b0;
      end
      if (pipe_if.ex2_update && !i_flush) begin
        r_tag_done[pipe_if.ex2_tag] <= 1'b1;
      end
    end
  end

  always_ff @(posedge i_clk) begin
    if (pipe_if.ex2_update) begin
      r_done_tag  <= pipe_if.ex2_tag;
      r_done_op   <= pipe_if.ex2_op;
      r_done_addr <= pipe_if.ex2_addr;
    end
  end

  assign o_done      = r_done;
  assign o_done_tag  = r_done_tag;
  assign o_done_op   = r_done_op;
  assign o_done_addr = r_done_addr;

  // A tag needs a fresh put and issue before it may complete again
  a_no_double_done: assert property (@(posedge i_clk) disable iff (!i_reset_n)
    (pipe_if.ex2_update && !i_flush) |-> !r_tag_done[pipe_if.ex2_tag]);

endmodule

`default_nettype wire

//--- lsu_sched_top.sv
/*
  Top level of the LSU issue scheduler. Plain ports in, decode into the
  issue queue, execute pipe and result stage.
*/
`timescale 1ns/1ps
`default_nettype none

module lsu_sched_top
  import lsu_sched_pkg::*;
(
  input  logic                  i_clk,
  input  logic                  i_reset_n,
  // Micro-op put
  input  logic                  i_put,
  input  lsu_op_t               i_put_op,
  input  logic [LSU_TAG_W-1:0]  i_put_tag,
  input  logic [LSU_RNID_W-1:0] i_put_rs1_rnid,
  input  logic                  i_put_rs1_ready,
  input  logic [LSU_XLEN-1:0]   i_put_rs1_data,
  input  logic [LSU_XLEN-1:0]   i_put_imm,
  output logic                  o_full,
  // Register writeback
  input  logic                  i_wr_valid,
  input  logic [LSU_RNID_W-1:0] i_wr_rnid,
  input  logic [LSU_XLEN-1:0]   i_wr_data,
  input  logic                  i_tlb_resolve,
  input  logic                  i_flush,
  // Completion
  output logic                  o_done,
  output logic [LSU_TAG_W-1:0]  o_done_tag,
  output lsu_op_t               o_done_op,
  output logic [LSU_XLEN-1:0]   o_done_addr
);

  logic             w_alloc;
  lsu_issue_entry_t w_alloc_entry;

  lsu_pipe_if pipe_if ();

  lsu_issue_decode u_decode (
    .i_put           (i_put),
    .i_put_op        (i_put_op),
    .i_put_tag       (i_put_tag),
    .i_put_rs1_rnid  (i_put_rs1_rnid),
    .i_put_rs1_ready (i_put_rs1_ready),
    .i_put_rs1_data  (i_put_rs1_data),
    .i_put_imm       (i_put_imm),
    .i_full          (o_full),
    .i_wr_valid      (i_wr_valid),
    .i_wr_rnid       (i_wr_rnid),
    .i_wr_data       (i_wr_data),
    .o_alloc         (w_alloc),
    .o_entry         (w_alloc_entry)
  );

  lsu_issue_queue u_queue (
    .i_clk         (i_clk),
    .i_reset_n     (i_reset_n),
    .i_alloc       (w_alloc),
    .i_alloc_entry (w_alloc_entry),
    .i_wr_valid    (i_wr_valid),
    .i_wr_rnid     (i_wr_rnid),
    .i_wr_data     (i_wr_data),
    .i_tlb_resolve (i_tlb_resolve),
    .i_flush       (i_flush),
    .pipe_if       (pipe_if.queue),
    .o_full        (o_full)
  );

  lsu_exec_pipe u_pipe (
    .i_clk     (i_clk),
    .i_reset_n (i_reset_n),
    .i_flush   (i_flush),
    .pipe_if   (pipe_if.pipe)
  );

  lsu_result u_result (
    .i_clk       (i_clk),
    .i_reset_n   (i_reset_n),
    .i_flush     (i_flush),
    .pipe_if     (pipe_if.pipe),
    .o_done      (o_done),
    .o_done_tag  (o_done_tag),
    .o_done_op   (o_done_op),
    .o_done_addr (o_done_addr)
  );

endmodule

`default_nettype wire

//--- tb_lsu_sched.sv
/*
  Testbench for the LSU issue scheduler. Random puts, writebacks, resolves
  and rare flushes from a fixed seed, checked against an in-flight op model.
*/
`timescale 1ns/1ps
`default_nettype none

module tb_lsu_sched
  import lsu_sched_pkg::*;
();

  localparam int STIM_CYCLES  = 400;
  localparam int DRAIN_CYCLES = 200;
  localparam int CLK_PERIOD   = 20;
  localparam int NUM_TAGS     = 1 << LSU_TAG_W;

  logic                  clk;
  logic                  reset_n;
  logic                  put;
  lsu_op_t               put_op;
  logic [LSU_TAG_W-1:0]  put_tag;
  logic [LSU_RNID_W-1:0] put_rnid;
  logic                  put_ready;
  logic [LSU_XLEN-1:0]   put_data;
  logic [LSU_XLEN-1:0]   put_imm;
  logic                  full;
  logic                  wr_valid;
  logic [LSU_RNID_W-1:0] wr_rnid;
  logic [LSU_XLEN-1:0]   wr_data;
  logic                  tlb_resolve;
  logic                  flush;
  logic                  done;
  logic [LSU_TAG_W-1:0]  done_tag;
  lsu_op_t               done_op;
  logic [LSU_XLEN-1:0]   done_addr;

  // In-flight ops, indexed by tag
  logic                  m_valid    [NUM_TAGS];
  lsu_op_t               m_op       [NUM_TAGS];
  logic                  m_ready    [NUM_TAGS];
  logic [LSU_XLEN-1:0]   m_base     [NUM_TAGS];
  logic [LSU_XLEN-1:0]   m_imm      [NUM_TAGS];
  logic [LSU_RNID_W-1:0] m_rnid     [NUM_TAGS];
  int                    m_order    [NUM_TAGS]; // Put order
  logic                  m_resolved [NUM_TAGS]; // Resolve seen after put

  integer               seed = 32'h7c31ac07;
  int                   errors;
  int                   completions;
  int                   put_count;
  logic [LSU_TAG_W-1:0] next_tag;

  lsu_sched_top DUT (
    .i_clk (clk), .i_reset_n (reset_n),
    .i_put (put), .i_put_op (put_op), .i_put_tag (put_tag),
    .i_put_rs1_rnid (put_rnid), .i_put_rs1_ready (put_ready),
    .i_put_rs1_data (put_data), .i_put_imm (put_imm), .o_full (full),
    .i_wr_valid (wr_valid), .i_wr_rnid (wr_rnid), .i_wr_data (wr_data),
    .i_tlb_resolve (tlb_resolve), .i_flush (flush),
    .o_done (done), .o_done_tag (done_tag), .o_done_op (done_op),
    .o_done_addr (done_addr)
  );

  initial begin
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  function automatic int rand_below(input int n);
    return ($random(seed) & 32'h7fff_ffff) % n;
  endfunction

  function automatic int count_in_flight();
    int n;
    n = 0;
    for (int i = 0; i < NUM_TAGS; i++)
      if (m_valid[i]) n++;
    return n;
  endfunction

  // --------------------------------------------------------------------------
  // Completion check against the model
  // --------------------------------------------------------------------------
  task automatic check_done();
    int                  t;
    logic [LSU_XLEN-1:0] exp_addr;
    t = int'(done_tag);
    completions++;
    if (!m_valid[t]) begin
      $display("FAIL %0t: tag %0d completed but is not in flight", $time, t);
      errors++;
      return;
    end
    exp_addr = m_base[t] + m_imm[t];
    if (!m_ready[t]) begin
      $display("FAIL %0t: tag %0d completed before its base was written", $time, t);
      errors++;
    end else if (done_addr !== exp_addr) begin
      $display("FAIL %0t: tag %0d addr %h, expected %h", $time, t, done_addr, exp_addr);
      errors++;
    end else if (exp_addr[LSU_XLEN-1] && !m_resolved[t]) begin
      $display("FAIL %0t: tag %0d missed but completed without resolve", $time, t);
      errors++;
    end
    if (done_op !== m_op[t]) begin
      $display("FAIL %0t: tag %0d op %0d, expected %0d", $time, t, done_op, m_op[t]);
      errors++;
    end
    for (int i = 0; i < NUM_TAGS; i++) begin
      if (m_op[t] == LSU_OP_STORE && m_valid[i] && m_order[i] < m_order[t]) begin
        $display("FAIL %0t: store tag %0d passed older tag %0d", $time, t, i);
        errors++;
      end
    end
    m_valid[t] = 1'b0;
  endtask

  // --------------------------------------------------------------------------
  // Inputs for the next edge, and the model's view of that edge
  // --------------------------------------------------------------------------
  task automatic drive_cycle(input bit stim, input int n_before);
    int pend[$];
    int oldest;
    int t;
    put         = 1'b0;
    wr_valid    = 1'b0;
    oldest      = -1;
    for (int i = 0; i < NUM_TAGS; i++) begin
      if (m_valid[i] && !m_ready[i]) begin
        pend.push_back(i);
        if (oldest < 0 || m_order[i] < m_order[oldest])
          oldest = i;
      end
    end
    if (pend.size() > 0 && (!stim || rand_below(4) != 0)) begin
      t        = (rand_below(2) == 0) ? oldest : pend[rand_below(pend.size())];
      wr_valid = 1'b1;
      wr_rnid  = m_rnid[t];
      wr_data  = LSU_XLEN'($random(seed));
    end
    tlb_resolve = (rand_below(stim ? 4 : 2) == 0);
    flush       = stim && (rand_below(80) == 0);
    if (flush) begin
      for (int i = 0; i < NUM_TAGS; i++)
        m_valid[i] = 1'b0;
      return;
    end
    for (int i = 0; i < NUM_TAGS; i++) begin
      if (m_valid[i] && tlb_resolve)
        m_resolved[i] = 1'b1;
      if (m_valid[i] && !m_ready[i] && wr_valid && wr_rnid == m_rnid[i]) begin
        m_ready[i] = 1'b1;
        m_base[i]  = wr_data;
      end
    end
    if (stim && n_before < LSU_QUEUE_DEPTH && rand_below(2) == 0) begin
      while (m_valid[next_tag])
        next_tag = next_tag + 1'b1;  // Skip tags still in flight
      put           = 1'b1;
      put_tag       = next_tag;
      put_op        = (rand_below(2) == 0) ? LSU_OP_LOAD : LSU_OP_STORE;
      put_rnid      = LSU_RNID_W'($random(seed));
      put_ready     = (rand_below(2) == 0);
      put_data      = LSU_XLEN'($random(seed));
      put_imm       = LSU_XLEN'($random(seed));
      t             = int'(next_tag);
      m_valid[t]    = 1'b1;
      m_op[t]       = put_op;
      m_rnid[t]     = put_rnid;
      m_imm[t]      = put_imm;
      m_order[t]    = put_count;
      m_resolved[t] = 1'b0;
      m_ready[t]    = put_ready;
      m_base[t]     = put_data;
      if (!put_ready && wr_valid && wr_rnid == put_rnid) begin
        m_ready[t] = 1'b1;  // Caught in the put cycle
        m_base[t]  = wr_data;
      end
      put_count++;
      next_tag = next_tag + 1'b1;
    end
  endtask

  initial begin
    int n_before;
    errors      = 0;
    completions = 0;
    put_count   = 0;
    next_tag    = '0;
    for (int i = 0; i < NUM_TAGS; i++)
      m_valid[i] = 1'b0;
    reset_n     = 1'b0;
    put         = 1'b0;
    put_op      = LSU_OP_LOAD;
    put_tag     = '0;
    put_rnid    = '0;
    put_ready   = 1'b0;
    put_data    = '0;
    put_imm     = '0;
    wr_valid    = 1'b0;
    wr_rnid     = '0;
    wr_data     = '0;
    tlb_resolve = 1'b0;
    flush       = 1'b0;
    repeat (2) @(posedge clk);
    @(negedge clk);
    reset_n = 1'b1;
    for (int c = 0; c < STIM_CYCLES + DRAIN_CYCLES; c++) begin
      @(negedge clk);
      n_before = count_in_flight();
      if (full !== (n_before == LSU_QUEUE_DEPTH)) begin
        $display("FAIL %0t: full is %b with %0d ops in flight", $time, full, n_before);
        errors++;
      end
      if (done === 1'b1)
        check_done();
      drive_cycle(c < STIM_CYCLES, n_before);
    end
    if (count_in_flight() != 0) begin
      $display("Ops still in flight after the drain: %0d", count_in_flight());
      errors++;
    end
    $display("Summary: %0d errors, %0d puts, %0d completions", errors, put_count, completions);
    if (errors == 0) begin
      $display("All tests passed!");
    end else begin
      $display("Test failures found");
    end
    $finish;
  end

  // Watchdog, a little past stimulus plus drain
  initial begin
    #((STIM_CYCLES + DRAIN_CYCLES + 20) * CLK_PERIOD);
    $display("Watchdog expired before the run ended");
    $display("Test failures found");
    $finish;
  end

endmodule

`default_nettype wire

//--- lsu_sched_top.f
lsu_sched_pkg.sv
lsu_pipe_if.sv
lsu_issue_decode.sv
lsu_issue_entry.sv
lsu_issue_queue.sv
lsu_exec_pipe.sv
lsu_result.sv
lsu_sched_top.sv
tb_lsu_sched.sv

//--- Makefile
TOOL     = verilator
FLAGS    = --binary --timing --assert -Wno-fatal
TOP      = tb_lsu_sched
FILELIST = lsu_sched_top.f
OBJ_DIR  = obj_dir
LOG      = sim.log
FAIL_MSG = Test failures found

.PHONY: all compile run clean

all: run

compile:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR) -o V$(TOP)

run: compile
	@./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if [ $$status -ne 0 ] || grep -q "$(FAIL_MSG)" $(LOG); then \
	  echo "Simulation failed, see $(LOG)"; exit 1; \
	fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)
